/* source/bus_pkg.sv */
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// data bus of the I/O fabric, slot map and register offsets
////////////////////////////////////////////////////////////////////////////

package bus_pkg;

  typedef logic [31:0] word_t;     // one bus data word
  typedef logic [23:0] addr_t;     // byte address
  typedef logic [3:0]  slot_t;     // top address nibble
  typedef logic [3:0]  reg_off_t;  // word offset inside a slot

  localparam int NUM_SLOTS = 16;
  localparam int SLOT_LSB  = 20;   // slot in addr[23:20]
  localparam int OFF_LSB   = 2;    // offset in addr[5:2]

  // slot map
  localparam slot_t SLOT_FILTER = 4'd6;
  localparam slot_t SLOT_LED    = 4'd7;

  // registers in the filter slot
  localparam reg_off_t REG_DIVISOR = 4'd0;
  localparam reg_off_t REG_LEVELS  = 4'd1;
  localparam reg_off_t REG_CHANGED = 4'd2;

  localparam word_t UNMAPPED_WORD = 32'hDEADBEEF;  // unmapped offset marker

  localparam int LED_W = 8;
  localparam int DIP_W = 16;

endpackage

`default_nettype wire

/* source/io_pkg.sv */
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// input line filter bank
////////////////////////////////////////////////////////////////////////////

package io_pkg;

  typedef logic [15:0] div_t;  // sample strobe divisor

  // gives a tick every 88 clocks out of reset
  localparam div_t DIV_RESET = 16'd87;

  localparam int NUM_LINES_DEFAULT = 4;

  // samples kept for the vote, an odd count
  localparam int HIST_W = 3;

endpackage

`default_nettype wire

/* source/sample_strobe_gen.sv */
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// sample strobe for the filter bank, one tick every divisor+1 clocks
////////////////////////////////////////////////////////////////////////////

module sample_strobe_gen
  (
  input  wire             msoc_clk,
  input  wire             rstn,
  input  wire io_pkg::div_t divisor_i,
  output logic            sample_tick_o
  );

  import io_pkg::*;

  div_t cnt_q;    // running count
  logic cnt_hit;

  // a divisor written below the running count ends the period at once
  assign cnt_hit = (cnt_q >= divisor_i);

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      cnt_q         <= '0;
      sample_tick_o <= 1'b0;
    end
    else
    begin
      sample_tick_o <= cnt_hit;  // single cycle pulse
      if (cnt_hit)
        cnt_q <= '0;             // restart after each tick
      else
        cnt_q <= cnt_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* source/line_filter.sv */
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// majority vote filter for one asynchronous input line
////////////////////////////////////////////////////////////////////////////

module line_filter
  (
  input  wire  msoc_clk,
  input  wire  rstn,
  input  wire  sample_tick_i,
  input  wire  line_i,
  output logic level_o
  );

  import io_pkg::*;

  logic [1:0]        sync_q;   // two flop synchronizer
  logic [HIST_W-1:0] hist_q;   // sample history, newest in bit 0
  logic [HIST_W-1:0] hist_nxt;

  // more than half of the samples high
  function automatic logic majority(input logic [HIST_W-1:0] h);
    int ones;
    ones = 0;
    for (int i = 0; i < HIST_W; i++)
    begin
      ones += int'(h[i]);
    end
    return (ones > HIST_W / 2);
  endfunction

  // vote on the history including the sample being taken
  assign hist_nxt = {hist_q[HIST_W-2:0], sync_q[1]};

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      sync_q  <= '0;
      hist_q  <= '0;
      level_o <= 1'b0;
    end
    else
    begin
      sync_q <= {sync_q[0], line_i};
      if (sample_tick_i)
      begin
        hist_q  <= hist_nxt;
        level_o <= majority(hist_nxt);  // one odd sample is outvoted
      end
    end
  end

endmodule

`default_nettype wire

/* source/io_regs.sv */
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// slot decode, LED/DIP register and filter status registers
////////////////////////////////////////////////////////////////////////////

module io_regs #(
  parameter int NUM_LINES = io_pkg::NUM_LINES_DEFAULT
  )
  (
  input  wire                        msoc_clk,
  input  wire                        rstn,
  input  wire                        bus_req_i,
  input  wire                        bus_we_i,
  input  wire bus_pkg::addr_t        bus_addr_i,
  input  wire bus_pkg::word_t        bus_wdata_i,
  input  wire [bus_pkg::DIP_W-1:0]   dip_i,
  input  wire [NUM_LINES-1:0]        levels_i,
  output bus_pkg::word_t             bus_rdata_o,
  output logic                       bus_rvalid_o,
  output logic [bus_pkg::LED_W-1:0]  led_o,
  output io_pkg::div_t               divisor_o
  );

  import bus_pkg::*;
  import io_pkg::*;

  slot_t                slot;
  reg_off_t             reg_off;
  logic [NUM_SLOTS-1:0] slot_sel;      // one-hot slot decode
  logic                 wr_en;
  logic                 rd_en;
  word_t                slot_rdata [NUM_SLOTS];
  word_t                filter_rdata;
  word_t                rd_word;
  logic [DIP_W-1:0]     dip_q;         // sampled switches
  logic [NUM_LINES-1:0] levels_q;      // previous filtered levels
  logic [NUM_LINES-1:0] changed_q;     // sticky change flags
  logic [NUM_LINES-1:0] changed_clr;

  assign slot    = bus_addr_i[SLOT_LSB +: $bits(slot_t)];
  assign reg_off = bus_addr_i[OFF_LSB +: $bits(reg_off_t)];
  assign wr_en   = bus_req_i & bus_we_i;
  assign rd_en   = bus_req_i & ~bus_we_i;

  always_comb
  begin
    for (int i = 0; i < NUM_SLOTS; i++)
    begin
      slot_sel[i] = (slot == slot_t'(i));
    end
  end

  // write one to clear
  assign changed_clr = (wr_en && slot_sel[SLOT_FILTER] && reg_off == REG_CHANGED) ?
                       bus_wdata_i[NUM_LINES-1:0] : '0;

  ////////////////////////////////////////////////////////////////////////////
  // control registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      led_o        <= '0;
      divisor_o    <= DIV_RESET;
      dip_q        <= '0;
      levels_q     <= '0;
      changed_q    <= '0;
      bus_rvalid_o <= 1'b0;
    end
    else
    begin
      dip_q        <= dip_i;
      levels_q     <= levels_i;
      bus_rvalid_o <= rd_en;     // data follow one cycle later
      // a new change wins over a clear in the same cycle
      changed_q    <= (changed_q & ~changed_clr) | (levels_i ^ levels_q);
      if (wr_en && slot_sel[SLOT_LED])
        led_o <= bus_wdata_i[LED_W-1:0];
      if (wr_en && slot_sel[SLOT_FILTER] && reg_off == REG_DIVISOR)
        divisor_o <= div_t'(bus_wdata_i);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // readback
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (reg_off)
      REG_DIVISOR: filter_rdata = word_t'(divisor_o);
      REG_LEVELS:  filter_rdata = word_t'(levels_i);
      REG_CHANGED: filter_rdata = word_t'(changed_q);
      default:     filter_rdata = UNMAPPED_WORD;
    endcase
  end

  always_comb
  begin
    for (int i = 0; i < NUM_SLOTS; i++)
    begin
      slot_rdata[i] = '0;        // unused slots read zero
    end
    slot_rdata[SLOT_FILTER] = filter_rdata;
    slot_rdata[SLOT_LED]    = word_t'(dip_q);
  end

  always_comb
  begin
    rd_word = '0;
    for (int i = 0; i < NUM_SLOTS; i++)
    begin
      if (slot_sel[i])
        rd_word |= slot_rdata[i];
    end
  end

  always_ff @(posedge msoc_clk)
  begin
    if (rd_en)
      bus_rdata_o <= rd_word;
  end

endmodule

`default_nettype wire

/* source/minion_io.sv */
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// memory-mapped I/O fabric with LED/switch register and line filters
////////////////////////////////////////////////////////////////////////////

module minion_io #(
  parameter int NUM_LINES = io_pkg::NUM_LINES_DEFAULT
  )
  (
  input  wire                        msoc_clk,
  input  wire                        rstn,
  // data bus
  input  wire                        bus_req_i,
  input  wire                        bus_we_i,
  input  wire bus_pkg::addr_t        bus_addr_i,
  input  wire bus_pkg::word_t        bus_wdata_i,
  output bus_pkg::word_t             bus_rdata_o,
  output logic                       bus_rvalid_o,
  // board I/O
  input  wire [bus_pkg::DIP_W-1:0]   dip_i,
  output logic [bus_pkg::LED_W-1:0]  led_o,
  input  wire [NUM_LINES-1:0]        line_i
  );

  import io_pkg::*;

  div_t                 divisor;
  logic                 sample_tick;   // shared by all filters
  logic [NUM_LINES-1:0] levels;

  sample_strobe_gen u_strobe (
    .msoc_clk      (msoc_clk),
    .rstn          (rstn),
    .divisor_i     (divisor),
    .sample_tick_o (sample_tick)
  );

  // one filter per external line
  for (genvar i = 0; i < NUM_LINES; i++)
  begin : g_filter
    line_filter u_filter (
      .msoc_clk      (msoc_clk),
      .rstn          (rstn),
      .sample_tick_i (sample_tick),
      .line_i        (line_i[i]),
      .level_o       (levels[i])
    );
  end

  io_regs #(
    .NUM_LINES (NUM_LINES)
  ) u_regs (
    .msoc_clk     (msoc_clk),
    .rstn         (rstn),
    .bus_req_i    (bus_req_i),
    .bus_we_i     (bus_we_i),
    .bus_addr_i   (bus_addr_i),
    .bus_wdata_i  (bus_wdata_i),
    .dip_i        (dip_i),
    .levels_i     (levels),
    .bus_rdata_o  (bus_rdata_o),
    .bus_rvalid_o (bus_rvalid_o),
    .led_o        (led_o),
    .divisor_o    (divisor)
  );

endmodule

`default_nettype wire

/* test/tb_checker.sv */
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// shadow model of the I/O fabric and read response comparison
////////////////////////////////////////////////////////////////////////////

module tb_checker #(
  parameter int NUM_LINES     = io_pkg::NUM_LINES_DEFAULT,
  parameter int STABLE_CYCLES = 16   // settle bound for a divisor of 3
  )
  (
  input  wire                      msoc_clk,
  input  wire                      rstn,
  input  wire                      bus_req_i,
  input  wire                      bus_we_i,
  input  wire bus_pkg::addr_t      bus_addr_i,
  input  wire bus_pkg::word_t      bus_wdata_i,
  input  wire [bus_pkg::DIP_W-1:0] dip_i,
  input  wire [NUM_LINES-1:0]      line_i,
  input  wire bus_pkg::word_t      bus_rdata_i,
  input  wire                      bus_rvalid_i,
  input  wire [bus_pkg::LED_W-1:0] led_i,
  output int                       errors_o,
  output int                       reads_o
  );

  import bus_pkg::*;
  import io_pkg::*;

  logic [LED_W-1:0]     led_sh;
  div_t                 div_sh;
  logic [DIP_W-1:0]     dip_sh;      // switches as last sampled
  logic [NUM_LINES-1:0] line_last;
  logic [NUM_LINES-1:0] level_sh;    // settled line levels
  logic [NUM_LINES-1:0] flag_sh;
  int                   stable_cnt [NUM_LINES];
  logic                 active;
  logic                 exp_pend;    // read taken at the last rising edge
  addr_t                exp_addr;
  word_t                exp_word;

  function automatic word_t expected_read(input addr_t addr, input div_t div,
    input logic [DIP_W-1:0] dip, input logic [NUM_LINES-1:0] lv,
    input logic [NUM_LINES-1:0] fl);
    if (addr[23:20] == SLOT_LED)
      return word_t'(dip);
    if (addr[23:20] != SLOT_FILTER)
      return '0;                     // unused slot
    case (addr[5:2])
      REG_DIVISOR: return word_t'(div);
      REG_LEVELS:  return word_t'(lv);
      REG_CHANGED: return word_t'(fl);
      default:     return UNMAPPED_WORD;
    endcase
  endfunction

  // inputs are stable at the rising edge
  always @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      led_sh    = '0;
      div_sh    = div_t'(87);        // divisor out of reset
      dip_sh    = '0;
      line_last = '0;
      level_sh  = '0;
      flag_sh   = '0;
      active    = 1'b0;
      exp_pend  = 1'b0;
      for (int i = 0; i < NUM_LINES; i++)
        stable_cnt[i] = 0;
    end
    else
    begin
      active   = 1'b1;
      exp_pend = bus_req_i && !bus_we_i;
      exp_addr = bus_addr_i;
      exp_word = expected_read(bus_addr_i, div_sh, dip_sh, level_sh, flag_sh);
      if (bus_req_i && bus_we_i && bus_addr_i[23:20] == SLOT_LED)
        led_sh = bus_wdata_i[LED_W-1:0];
      if (bus_req_i && bus_we_i && bus_addr_i[23:20] == SLOT_FILTER)
      begin
        if (bus_addr_i[5:2] == REG_DIVISOR)
          div_sh = bus_wdata_i[15:0];
        if (bus_addr_i[5:2] == REG_CHANGED)
          flag_sh = flag_sh & ~bus_wdata_i[NUM_LINES-1:0];  // write one to clear
      end
      dip_sh = dip_i;
      for (int i = 0; i < NUM_LINES; i++)
      begin
        stable_cnt[i] = (line_i[i] == line_last[i]) ? stable_cnt[i] + 1 : 0;
        if (stable_cnt[i] >= STABLE_CYCLES && line_i[i] != level_sh[i])
        begin
          level_sh[i] = line_i[i];   // a held change gets through the vote
          flag_sh[i]  = 1'b1;
        end
      end
      line_last = line_i;
    end
  end

  // outputs are stable at the falling edge
  always @(negedge msoc_clk)
  begin
    if (!rstn)
    begin
      errors_o = 0;
      reads_o  = 0;
    end
    else if (active === 1'b1)
    begin
      if (led_i !== led_sh)
      begin
        errors_o++;
        $display("MISMATCH at %0t ns: led_o is %h, expected %h", $time, led_i, led_sh);
      end
      if (bus_rvalid_i !== exp_pend)
      begin
        errors_o++;
        $display("error at %0t ns: read valid %s", $time,
                 exp_pend ? "missing after a read request" : "without a read request");
      end
      else if (exp_pend)
      begin
        reads_o++;
        if (bus_rdata_i !== exp_word)
        begin
          errors_o++;
          $display("MISMATCH at %0t ns: read of %h gave %h, expected %h",
                   $time, exp_addr, bus_rdata_i, exp_word);
        end
      end
    end
  end

endmodule

`default_nettype wire

/* test/tb_minion_io.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_minion_io;

  import bus_pkg::*;
  import io_pkg::*;

  localparam int NUM_LINES      = NUM_LINES_DEFAULT;
  localparam int HOLD_CYCLES    = 20;    // line hold before a level read
  localparam int TIMEOUT_CYCLES = 3000;  // sequence runs well under this

  logic                 msoc_clk;
  logic                 rstn;
  logic                 bus_req;
  logic                 bus_we;
  addr_t                bus_addr;
  word_t                bus_wdata;
  word_t                bus_rdata;
  logic                 bus_rvalid;
  logic [DIP_W-1:0]     dip;
  logic [LED_W-1:0]     led;
  logic [NUM_LINES-1:0] line;
  int                   errors;
  int                   reads;
  int                   cycle_cnt;
  integer               seed;

  always #50 msoc_clk = ~msoc_clk;   // 100 ns period

  minion_io #(
    .NUM_LINES (NUM_LINES)
  ) dut0 (
    .msoc_clk     (msoc_clk),
    .rstn         (rstn),
    .bus_req_i    (bus_req),
    .bus_we_i     (bus_we),
    .bus_addr_i   (bus_addr),
    .bus_wdata_i  (bus_wdata),
    .bus_rdata_o  (bus_rdata),
    .bus_rvalid_o (bus_rvalid),
    .dip_i        (dip),
    .led_o        (led),
    .line_i       (line)
  );

  tb_checker #(
    .NUM_LINES (NUM_LINES)
  ) u_checker (
    .msoc_clk     (msoc_clk),
    .rstn         (rstn),
    .bus_req_i    (bus_req),
    .bus_we_i     (bus_we),
    .bus_addr_i   (bus_addr),
    .bus_wdata_i  (bus_wdata),
    .dip_i        (dip),
    .line_i       (line),
    .bus_rdata_i  (bus_rdata),
    .bus_rvalid_i (bus_rvalid),
    .led_i        (led),
    .errors_o     (errors),
    .reads_o      (reads)
  );

  function automatic addr_t bus_address(input slot_t slot, input reg_off_t off);
    addr_t addr;
    addr        = '0;
    addr[23:20] = slot;
    addr[5:2]   = off;
    return addr;
  endfunction

  // request stays up until the next call or bus_idle
  task automatic bus_request(input logic we, input slot_t slot, input reg_off_t off,
                             input word_t data);
    @(negedge msoc_clk);
    bus_req   = 1'b1;
    bus_we    = we;
    bus_addr  = bus_address(slot, off);
    bus_wdata = data;
  endtask

  task automatic bus_idle(input int n);
    repeat (n)
    begin
      @(negedge msoc_clk);
      bus_req = 1'b0;
      bus_we  = 1'b0;
    end
  endtask

  task automatic hold_and_read();
    bus_idle(HOLD_CYCLES);
    bus_request(1'b0, SLOT_FILTER, REG_LEVELS, '0);
    bus_request(1'b0, SLOT_FILTER, REG_CHANGED, '0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    seed      = 13;
    msoc_clk  = 1'b0;
    rstn      = 1'b0;
    bus_req   = 1'b0;
    bus_we    = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    dip       = '0;
    line      = '0;
    repeat (4) @(negedge msoc_clk);
    rstn = 1'b1;
    bus_request(1'b0, SLOT_FILTER, REG_DIVISOR, '0);  // reset values
    bus_request(1'b0, SLOT_FILTER, REG_CHANGED, '0);
    bus_idle(2);
    for (int k = 0; k < 8; k++)
    begin
      bus_request(1'b1, SLOT_LED, reg_off_t'(k), $random(seed));
      dip = DIP_W'($random(seed));
      bus_idle(2);
      bus_request(1'b0, SLOT_LED, reg_off_t'(k), '0);
    end
    for (int s = 0; s < 16; s++)
    begin
      if (s != SLOT_FILTER && s != SLOT_LED)
        bus_request(1'b0, slot_t'(s), reg_off_t'($random(seed)), '0);
    end
    for (int r = 3; r < 16; r++)
      bus_request(1'b0, SLOT_FILTER, reg_off_t'(r), '0);  // unmapped offsets
    bus_request(1'b1, SLOT_FILTER, REG_DIVISOR, 32'd3);
    bus_request(1'b0, SLOT_FILTER, REG_DIVISOR, '0);
    for (int k = 0; k < 6; k++)
    begin
      bus_idle(1);
      line = NUM_LINES'($random(seed));
      hold_and_read();
    end
    bus_request(1'b1, SLOT_FILTER, REG_CHANGED, '1);
    for (int i = 0; i < NUM_LINES; i++)
    begin
      bus_idle(i + 1);               // each glitch at another tick phase
      line[i] = ~line[i];
      bus_idle(1);
      line[i] = ~line[i];            // single cycle glitch
      hold_and_read();
    end
    for (int i = 0; i < NUM_LINES; i++)
    begin
      bus_idle(1);
      line[i]                   = ~line[i];
      line[(i + 1) % NUM_LINES] = ~line[(i + 1) % NUM_LINES];
      hold_and_read();
      bus_request(1'b1, SLOT_FILTER, REG_CHANGED, word_t'(1) << i);  // neighbour flag stays
      bus_request(1'b0, SLOT_FILTER, REG_CHANGED, '0);
    end
    bus_idle(3);
    $display("closing report: %0d reads checked, %0d errors", reads, errors);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES)
    begin
      @(posedge msoc_clk);
      cycle_cnt++;
    end
    $display("timeout: sequence still running after %0d cycles, %0d errors so far",
             TIMEOUT_CYCLES, errors);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
source/bus_pkg.sv
source/io_pkg.sv
source/sample_strobe_gen.sv
source/line_filter.sv
source/io_regs.sv
source/minion_io.sv
test/tb_checker.sv
test/tb_minion_io.sv

/* Bender.yml */
package:
  name: minion_io

sources:
  - source/bus_pkg.sv
  - source/io_pkg.sv
  - source/sample_strobe_gen.sv
  - source/line_filter.sv
  - source/io_regs.sv
  - source/minion_io.sv
  - target: test
    files:
      - test/tb_checker.sv
      - test/tb_minion_io.sv
